// File: sources.f
+incdir+src
src/backendPkg.sv
src/ctrlIf.sv
src/ctrlUnitBackend.sv
src/instFetchBuffer.sv
src/renameDispatch.sv
src/issueQueue.sv
src/reorderBuffer.sv
src/backendTop.sv
bench/backendTb.sv

// File: run.sh
#!/bin/sh
# builds the backend testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f --top-module backendTb -o backendSim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/backendSim 2>&1)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -q "Regression passed"; then
    exit 0
fi
exit 1

// File: bench/backend_vectors.txt
// program at @00: pair count, then address and instruction word pairs (hex)
// trace at @40: commit count, then pc and flush-flag pairs; lsuGrant at @80: count, then bits
@00
18
00 00000001  01 40000000  02 80000000  03 40000001
04 C000000A  05 C0000000  0A 40000000  0B 40000000
0C 00000000  0D 80000000  0E C0000020  0F 40000000
20 00000000  21 40000000  22 40000000  23 40000000
24 40000000  25 80000000  26 C0000030  30 C0000032
31 80000000  32 00000000  33 40000000  34 C0000034
@40
17
00 0  01 0  02 0  03 0  04 1  0A 0  0B 0  0C 0
0D 0  0E 1  20 0  21 0  22 0  23 0  24 0  25 0
26 1  30 1  32 0  33 0  34 1  34 1  34 1
@80
28
1 1 0 0 0 0 0 0  0 0 0 0 0 0 0 0
1 0 0 0 0 0 0 0  0 0 0 1 1 1 0 0
0 0 0 0 0 0 0 0

// File: bench/backendTb.sv
`timescale 1ns/1ps

module backendTb;
    import backendPkg::*;

    localparam int VecWords = 256;
    localparam int ProgBase = 'h00;
    localparam int TraceBase = 'h40;
    localparam int GrantBase = 'h80;
    localparam int CyclesPerCommit = 200;

    logic clk;
    logic rst;
    logic wbCyc;
    logic wbStb;
    addrT wbAdr;
    instT wbDatI;
    logic wbAck;
    logic lsuGrant;
    logic commitValid;
    addrT commitPc;
    pTagT commitTag;
    logic commitFlush;

    logic [31:0] vec [VecWords];
    instT progMem [65536];
    addrT expPc [$];
    logic expFlush [$];
    logic grantPat [$];
    int commitCount = 0;
    int cycleCount = 0;
    int cycleLimit = 0;

    backendTop uut (
        .clk, .rst,
        .wbCyc, .wbStb, .wbAdr, .wbDatI, .wbAck,
        .lsuGrant,
        .commitValid, .commitPc, .commitTag, .commitFlush
    );

    always #2 clk = ~clk;

    // ------------------------------
    // checks
    // ------------------------------
    task automatic abortRun(input string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1, "run stopped at %0t", $time);
    endtask

    task automatic checkAddr(input string name, input addrT got, input addrT exp);
        if (got !== exp) begin
            abortRun($sformatf("error at %0t: %s is %h, expected %h", $time, name, got, exp));
        end
    endtask

    task automatic checkTag(input string name, input pTagT got, input pTagT exp);
        if (got !== exp) begin
            abortRun($sformatf("error at %0t: %s is %h, expected %h", $time, name, got, exp));
        end
    endtask

    task automatic checkBit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abortRun($sformatf("error at %0t: %s is %b, expected %b", $time, name, got, exp));
        end
    endtask

    task automatic loadVectors();
        int progCount;
        int traceCount;
        int grantCount;
        $readmemh("bench/backend_vectors.txt", vec);
        progCount = int'(vec[ProgBase]);
        traceCount = int'(vec[TraceBase]);
        grantCount = int'(vec[GrantBase]);
        if (progCount == 0 || traceCount == 0 || grantCount == 0) begin
            abortRun("the vector file is missing or one of its sections is empty");
        end
        // unlisted words decode as ALU and carry their own address
        for (int a = 0; a < 65536; a++) begin
            progMem[a] = instT'(a);
        end
        for (int i = 0; i < progCount; i++) begin
            progMem[vec[ProgBase + 1 + 2 * i][15:0]] = vec[ProgBase + 2 + 2 * i];
        end
        for (int i = 0; i < traceCount; i++) begin
            expPc.push_back(vec[TraceBase + 1 + 2 * i][15:0]);
            expFlush.push_back(vec[TraceBase + 2 + 2 * i][0]);
        end
        for (int i = 0; i < grantCount; i++) begin
            grantPat.push_back(vec[GrantBase + 1 + i][0]);
        end
        cycleLimit = CyclesPerCommit * traceCount;
    endtask

    // ------------------------------
    // wishbone memory and lsu grant
    // ------------------------------
    initial begin : wishboneMemory
        int unsigned seedInit;
        int waitLeft;
        bit busy;
        addrT reqAdr;
        seedInit = $urandom(59);
        waitLeft = 0;
        busy = 1'b0;
        reqAdr = '0;
        forever begin
            @(posedge clk);
            #1;
            lsuGrant = grantPat[cycleCount % grantPat.size()];
            if (rst) begin
                wbAck = 1'b0;
                busy = 1'b0;
            end else if (wbAck) begin
                // word was taken at this edge
                wbAck = 1'b0;
            end else if (busy || (wbCyc && wbStb)) begin
                if (!busy) begin
                    busy = 1'b1;
                    reqAdr = wbAdr;
                    waitLeft = int'($urandom % 4);
                end
                // the master keeps its request up until ack
                checkBit("wbCyc", wbCyc, 1'b1);
                checkBit("wbStb", wbStb, 1'b1);
                checkAddr("wbAdr", wbAdr, reqAdr);
                if (waitLeft == 0) begin
                    wbDatI = progMem[reqAdr];
                    wbAck = 1'b1;
                    busy = 1'b0;
                end else begin
                    waitLeft--;
                end
            end
        end
    end

    // commit monitor, sampled mid-cycle
    always @(negedge clk) begin
        if (!rst && commitValid) begin
            if (commitCount >= expPc.size()) begin
                abortRun("a commit appeared after the expected trace was complete");
            end
            checkAddr("commitPc", commitPc, expPc[commitCount]);
            checkBit("commitFlush", commitFlush, expFlush[commitCount]);
            // recovery hands back unused tags, so tags never skip
            checkTag("commitTag", commitTag, pTagT'(commitCount % 16));
            commitCount++;
        end else if (!rst) begin
            checkBit("commitFlush", commitFlush, 1'b0);
        end
        cycleCount++;
        if (commitCount < expPc.size() && cycleCount >= cycleLimit) begin
            abortRun($sformatf("timeout: %0d of %0d commits seen after %0d cycles",
                commitCount, expPc.size(), cycleCount));
        end
    end

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        wbDatI = '0;
        wbAck = 1'b0;
        lsuGrant = 1'b0;
        loadVectors();

        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;

        // idle bus and no commits before the first fetch
        @(negedge clk);
        checkBit("wbCyc", wbCyc, 1'b0);
        checkBit("wbStb", wbStb, 1'b0);
        checkBit("commitValid", commitValid, 1'b0);
        checkBit("commitFlush", commitFlush, 1'b0);

        while (commitCount < expPc.size()) begin
            @(posedge clk);
        end
        $display("Regression passed");
        $finish;
    end

endmodule

// File: src/backendTop.sv
`timescale 1ns/1ps

module backendTop (
    input  logic              clk,
    input  logic              rst,
    output logic              wbCyc,
    output logic              wbStb,
    output backendPkg::addrT  wbAdr,
    input  backendPkg::instT  wbDatI,
    input  logic              wbAck,
    input  logic              lsuGrant,
    output logic              commitValid,
    output backendPkg::addrT  commitPc,
    output backendPkg::pTagT  commitTag,
    output logic              commitFlush
);
    import backendPkg::*;

    logic decValid;
    addrT decPc;
    instT decInst;
    logic redirectValid;
    addrT redirectPc;
    logic aluReady;
    logic lsuReady;
    logic mduReady;
    logic tagAllocatable;
    logic aluFlush;
    logic lsuFlush;
    logic mduFlush;
    logic pauseRename;
    logic pauseDispatch;
    logic tagRecover;
    logic robAlloc;
    addrT allocPc;
    instClassT allocClass;
    pTagT allocTag;
    addrT allocTarget;
    robIdxT allocIdx;
    logic aluPush;
    logic lsuPush;
    logic mduPush;
    robIdxT pushIdx;
    logic doneAlu;
    logic doneLsu;
    logic doneMdu;
    robIdxT doneAluIdx;
    robIdxT doneLsuIdx;
    robIdxT doneMduIdx;

    Ctrl ctrlDecode ();
    Ctrl ctrlRename ();
    Ctrl ctrlRob ();
    Ctrl ctrlCommit ();

    ctrlUnitBackend ctrlUnit (
        .clk, .rst,
        .ctrlDecode, .ctrlRename, .ctrlRob, .ctrlCommit,
        .aluReady, .lsuReady, .mduReady, .tagAllocatable,
        .aluFlush, .lsuFlush, .mduFlush,
        .pauseRename, .pauseDispatch, .tagRecover
    );

    instFetchBuffer fetch (
        .clk, .rst, .ctrl(ctrlDecode),
        .wbCyc, .wbStb, .wbAdr, .wbDatI, .wbAck,
        .redirectValid, .redirectPc,
        .decValid, .decPc, .decInst
    );

    renameDispatch rename (
        .clk, .rst, .ctrl(ctrlRename),
        .pauseRename, .pauseDispatch, .tagRecover,
        .decValid, .decPc, .decInst,
        .commitFree(commitValid), .tagAllocatable,
        .robAlloc, .allocPc, .allocClass, .allocTag, .allocTarget,
        .robIdx(allocIdx),
        .aluPush, .lsuPush, .mduPush, .pushIdx
    );

    // ------------------------------
    // issue queues
    // ------------------------------
    issueQueue aluQueue (
        .clk, .rst, .flush(aluFlush), .push(aluPush), .pushIdx,
        .grant(1'b1), .ready(aluReady), .done(doneAlu), .doneIdx(doneAluIdx)
    );

    // memory port availability comes from outside
    issueQueue lsuQueue (
        .clk, .rst, .flush(lsuFlush), .push(lsuPush), .pushIdx,
        .grant(lsuGrant), .ready(lsuReady), .done(doneLsu), .doneIdx(doneLsuIdx)
    );

    issueQueue mduQueue (
        .clk, .rst, .flush(mduFlush), .push(mduPush), .pushIdx,
        .grant(1'b1), .ready(mduReady), .done(doneMdu), .doneIdx(doneMduIdx)
    );

    reorderBuffer rob (
        .clk, .rst, .ctrlRob, .ctrlCommit, .flush(aluFlush),
        .alloc(robAlloc), .allocPc, .allocClass, .allocTag, .allocTarget, .allocIdx,
        .doneAlu, .doneAluIdx, .doneLsu, .doneLsuIdx, .doneMdu, .doneMduIdx,
        .commitValid, .commitPc, .commitTag, .commitFlush,
        .redirectValid, .redirectPc
    );

endmodule

// File: src/reorderBuffer.sv
`timescale 1ns/1ps
`include "backend_defs.svh"

module reorderBuffer (
    input  logic                   clk,
    input  logic                   rst,
    Ctrl.slave                     ctrlRob,
    Ctrl.slave                     ctrlCommit,
    input  logic                   flush,
    input  logic                   alloc,
    input  backendPkg::addrT       allocPc,
    input  backendPkg::instClassT  allocClass,
    input  backendPkg::pTagT       allocTag,
    input  backendPkg::addrT       allocTarget,
    output backendPkg::robIdxT     allocIdx,
    input  logic                   doneAlu,
    input  backendPkg::robIdxT     doneAluIdx,
    input  logic                   doneLsu,
    input  backendPkg::robIdxT     doneLsuIdx,
    input  logic                   doneMdu,
    input  backendPkg::robIdxT     doneMduIdx,
    output logic                   commitValid,
    output backendPkg::addrT       commitPc,
    output backendPkg::pTagT       commitTag,
    output logic                   commitFlush,
    output logic                   redirectValid,
    output backendPkg::addrT       redirectPc
);
    import backendPkg::*;

    localparam int IdxW = $clog2(`ROB_DEPTH);

    addrT pcMem [`ROB_DEPTH];
    addrT targetMem [`ROB_DEPTH];
    instClassT classMem [`ROB_DEPTH];
    pTagT tagMem [`ROB_DEPTH];
    logic [`ROB_DEPTH-1:0] complete;
    logic [IdxW:0] head;
    logic [IdxW:0] tail;
    robIdxT headIdx;
    logic full;
    logic commitFire;

    assign headIdx = head[IdxW-1:0];
    assign allocIdx = tail[IdxW-1:0];
    assign full = (head[IdxW] != tail[IdxW]) && (headIdx == allocIdx);

    assign ctrlRob.pauseReq = full;
    assign ctrlRob.flushReq = 1'b0;
    assign ctrlCommit.pauseReq = 1'b0;
    assign ctrlCommit.flushReq = commitFlush;
    assign redirectValid = commitFlush;

    // nothing younger than a committed jump may follow it
    assign commitFire = (head != tail) && complete[headIdx] && !ctrlCommit.flush;

    // ------------------------------
    // pointers and completion bits
    // ------------------------------
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            head <= '0;
            tail <= '0;
            complete <= '0;
        end else begin
            if (alloc) begin
                tail <= tail + 1'b1;
                complete[allocIdx] <= 1'b0;
            end
            if (commitFire) begin
                head <= head + 1'b1;
            end
            if (doneAlu) complete[doneAluIdx] <= 1'b1;
            if (doneLsu) complete[doneLsuIdx] <= 1'b1;
            if (doneMdu) complete[doneMduIdx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            pcMem[allocIdx] <= allocPc;
            targetMem[allocIdx] <= allocTarget;
            classMem[allocIdx] <= allocClass;
            tagMem[allocIdx] <= allocTag;
        end
    end

    // commit outputs
    always_ff @(posedge clk) begin
        if (rst) begin
            commitValid <= 1'b0;
            commitFlush <= 1'b0;
        end else begin
            commitValid <= commitFire;
            commitFlush <= commitFire && (classMem[headIdx] == CLS_JUMP);
        end
    end

    always_ff @(posedge clk) begin
        if (commitFire) begin
            commitPc <= pcMem[headIdx];
            commitTag <= tagMem[headIdx];
            redirectPc <= targetMem[headIdx];
        end
    end

endmodule

// File: src/issueQueue.sv
`timescale 1ns/1ps
`include "backend_defs.svh"

module issueQueue (
    input  logic                clk,
    input  logic                rst,
    input  logic                flush,
    input  logic                push,
    input  backendPkg::robIdxT  pushIdx,
    input  logic                grant,
    output logic                ready,
    output logic                done,
    output backendPkg::robIdxT  doneIdx
);
    import backendPkg::*;

    localparam int PtrW = $clog2(`IQ_DEPTH);

    robIdxT mem [`IQ_DEPTH];
    logic [PtrW:0] head;
    logic [PtrW:0] tail;
    logic empty;
    logic full;

    assign empty = (head == tail);
    assign full = (head[PtrW] != tail[PtrW]) && (head[PtrW-1:0] == tail[PtrW-1:0]);
    assign ready = !full;

    // issuing an entry completes it at once
    assign done = !empty && grant && !flush;
    assign doneIdx = mem[head[PtrW-1:0]];

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            head <= '0;
            tail <= '0;
        end else begin
            if (push) begin
                tail <= tail + 1'b1;
            end
            if (done) begin
                head <= head + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[tail[PtrW-1:0]] <= pushIdx;
        end
    end

    // dispatch must have seen the full queue through the control unit
    assert property (@(posedge clk) disable iff (rst) push |-> ready);

endmodule

// File: src/renameDispatch.sv
`timescale 1ns/1ps
`include "backend_defs.svh"

module renameDispatch (
    input  logic                   clk,
    input  logic                   rst,
    Ctrl.slave                     ctrl,
    input  logic                   pauseRename,
    input  logic                   pauseDispatch,
    input  logic                   tagRecover,
    input  logic                   decValid,
    input  backendPkg::addrT       decPc,
    input  backendPkg::instT       decInst,
    input  logic                   commitFree,
    output logic                   tagAllocatable,
    output logic                   robAlloc,
    output backendPkg::addrT       allocPc,
    output backendPkg::instClassT  allocClass,
    output backendPkg::pTagT       allocTag,
    output backendPkg::addrT       allocTarget,
    input  backendPkg::robIdxT     robIdx,
    output logic                   aluPush,
    output logic                   lsuPush,
    output logic                   mduPush,
    output backendPkg::robIdxT     pushIdx
);
    import backendPkg::*;

    localparam int TagW = $clog2(`PTAG_COUNT);

    logic [TagW:0] allocPtr;
    logic [TagW:0] freePtr;
    logic tagTake;
    logic renValid;
    addrT renPc;
    instT renInst;
    pTagT renTag;
    instClassT renClass;

    assign ctrl.pauseReq = 1'b0;
    assign ctrl.flushReq = 1'b0;

    // ------------------------------
    // tag ring
    // ------------------------------
    assign tagAllocatable = (allocPtr - freePtr) != (TagW + 1)'(`PTAG_COUNT);
    assign tagTake = decValid && !pauseRename && tagAllocatable && !ctrl.flush;

    always_ff @(posedge clk) begin
        if (rst) begin
            allocPtr <= '0;
            freePtr <= '0;
        end else begin
            if (tagRecover) begin
                allocPtr <= freePtr;
            end else if (tagTake) begin
                allocPtr <= allocPtr + 1'b1;
            end
            if (commitFree) begin
                freePtr <= freePtr + 1'b1;
            end
        end
    end

    // rename register, tag is bound on entry
    always_ff @(posedge clk) begin
        if (rst || ctrl.flush) begin
            renValid <= 1'b0;
        end else if (!ctrl.pause) begin
            renValid <= decValid;
        end else if (robAlloc) begin
            renValid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!ctrl.pause) begin
            renPc <= decPc;
            renInst <= decInst;
            renTag <= pTagT'(allocPtr[TagW-1:0]);
        end
    end

    // ------------------------------
    // dispatch
    // ------------------------------
    assign renClass = instClassT'(renInst[31:30]);
    assign robAlloc = renValid && !pauseDispatch && !ctrl.flush;
    assign allocPc = renPc;
    assign allocClass = renClass;
    assign allocTag = renTag;
    assign allocTarget = renInst[`ADDR_W-1:0];

    // jumps resolve in the ALU queue
    assign aluPush = robAlloc && (renClass == CLS_ALU || renClass == CLS_JUMP);
    assign lsuPush = robAlloc && (renClass == CLS_LSU);
    assign mduPush = robAlloc && (renClass == CLS_MDU);
    assign pushIdx = robIdx;

endmodule

// File: src/instFetchBuffer.sv
`timescale 1ns/1ps

module instFetchBuffer (
    input  logic              clk,
    input  logic              rst,
    Ctrl.slave                ctrl,
    output logic              wbCyc,
    output logic              wbStb,
    output backendPkg::addrT  wbAdr,
    input  backendPkg::instT  wbDatI,
    input  logic              wbAck,
    input  logic              redirectValid,
    input  backendPkg::addrT  redirectPc,
    output logic              decValid,
    output backendPkg::addrT  decPc,
    output backendPkg::instT  decInst
);
    import backendPkg::*;

    fetchStateT state;
    addrT pc;
    addrT adrQ;
    instT holdWord;
    logic dropCycle;
    logic wordIn;
    logic holdOut;

    assign ctrl.pauseReq = 1'b0;
    assign ctrl.flushReq = 1'b0;

    assign wbCyc = (state == FETCH_WAIT);
    assign wbStb = wbCyc;
    assign wbAdr = adrQ;

    // a word returned after a flush is thrown away
    assign wordIn = wbCyc && wbAck && !dropCycle && !ctrl.flush;
    assign holdOut = (state == FETCH_HOLD) && !ctrl.flush;

    // ------------------------------
    // wishbone read master
    // ------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= FETCH_IDLE;
            pc <= '0;
            adrQ <= '0;
            dropCycle <= 1'b0;
        end else begin
            case (state)
                FETCH_IDLE: begin
                    if (!ctrl.flush) begin
                        state <= FETCH_WAIT;
                        adrQ <= pc;
                        pc <= pc + 1'b1;
                    end
                end
                FETCH_WAIT: begin
                    if (wbAck) begin
                        dropCycle <= 1'b0;
                        state <= (wordIn && ctrl.pause) ? FETCH_HOLD : FETCH_IDLE;
                    end else if (ctrl.flush) begin
                        dropCycle <= 1'b1;
                    end
                end
                FETCH_HOLD: begin
                    if (ctrl.flush || !ctrl.pause) begin
                        state <= FETCH_IDLE;
                    end
                end
                default: state <= FETCH_IDLE;
            endcase
            if (redirectValid) begin
                pc <= redirectPc;
            end
        end
    end

    // decode register
    always_ff @(posedge clk) begin
        if (rst || ctrl.flush) begin
            decValid <= 1'b0;
        end else if (!ctrl.pause) begin
            decValid <= wordIn || holdOut;
        end
    end

    always_ff @(posedge clk) begin
        if (wbCyc && wbAck) begin
            holdWord <= wbDatI;
        end
        if (!ctrl.pause) begin
            decPc <= adrQ;
            decInst <= (state == FETCH_HOLD) ? holdWord : wbDatI;
        end
    end

    // an open cycle keeps its address until the slave acks
    assert property (@(posedge clk) disable iff (rst)
        wbCyc && !wbAck |=> wbCyc && $stable(wbAdr));

endmodule

// File: src/ctrlUnitBackend.sv
`timescale 1ns/1ps

module ctrlUnitBackend (
    input  logic clk,
    input  logic rst,
    Ctrl.master  ctrlDecode,
    Ctrl.master  ctrlRename,
    Ctrl.master  ctrlRob,
    Ctrl.master  ctrlCommit,
    input  logic aluReady,
    input  logic lsuReady,
    input  logic mduReady,
    input  logic tagAllocatable,
    output logic aluFlush,
    output logic lsuFlush,
    output logic mduFlush,
    output logic pauseRename,
    output logic pauseDispatch,
    output logic tagRecover
);

    logic issueHold;
    logic renameHold;
    logic flushReqDly;
    logic flushAll;

    // ------------------------------
    // pause levels, each one narrower
    // ------------------------------
    assign issueHold = ctrlRob.pauseReq || !aluReady || !lsuReady || !mduReady;
    assign renameHold = issueHold || !tagAllocatable;

    assign ctrlDecode.pause = renameHold || ctrlRename.pauseReq;
    assign ctrlRename.pause = renameHold;
    assign pauseRename = issueHold;
    assign pauseDispatch = issueHold;

    // the ROB and commit stage are never stalled from here
    assign ctrlRob.pause = 1'b0;
    assign ctrlCommit.pause = 1'b0;

    // ------------------------------
    // flush, two cycles wide
    // ------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            flushReqDly <= 1'b0;
        end else begin
            flushReqDly <= ctrlCommit.flushReq;
        end
    end

    assign flushAll = flushReqDly || ctrlCommit.flushReq;

    assign ctrlDecode.flush = flushAll;
    assign ctrlRename.flush = flushAll;
    assign ctrlRob.flush = flushAll;
    assign ctrlCommit.flush = flushAll;
    assign aluFlush = flushAll;
    assign lsuFlush = flushAll;
    assign mduFlush = flushAll;

    // tag ring rolls back once the commit has freed the jump's own tag
    assign tagRecover = flushReqDly;

    // recover follows a single-cycle flush request from the ROB
    assert property (@(posedge clk) disable iff (rst)
        tagRecover |-> !ctrlCommit.flushReq);

endmodule

// File: src/ctrlIf.sv
`timescale 1ns/1ps

// pause and flush handshake between the control unit and one stage
interface Ctrl;
    logic pause;
    logic flush;
    logic pauseReq;
    logic flushReq;

    modport master (
        output pause, flush,
        input  pauseReq, flushReq
    );

    modport slave (
        input  pause, flush,
        output pauseReq, flushReq
    );
endinterface

// File: src/backendPkg.sv
`include "backend_defs.svh"

package backendPkg;

    // word address, one per 32-bit instruction
    typedef logic [`ADDR_W-1:0] addrT;

    typedef logic [`INST_W-1:0] instT;

    typedef logic [$clog2(`ROB_DEPTH)-1:0] robIdxT;

    typedef logic [$clog2(`PTAG_COUNT)-1:0] pTagT;

    // ------------------------------
    // encodings
    // ------------------------------

    // instruction bits 31:30
    typedef enum logic [1:0] {
        CLS_ALU  = 2'd0,
        CLS_LSU  = 2'd1,
        CLS_MDU  = 2'd2,
        CLS_JUMP = 2'd3
    } instClassT;

    typedef enum logic [1:0] {
        FETCH_IDLE = 2'd0,
        FETCH_WAIT = 2'd1,
        FETCH_HOLD = 2'd2
    } fetchStateT;

endpackage

// File: src/backend_defs.svh
`ifndef BACKEND_DEFS_SVH
`define BACKEND_DEFS_SVH

// instruction word address and instruction widths
`define ADDR_W 16
`define INST_W 32

// ------------------------------
// buffer depths
// ------------------------------
`define ROB_DEPTH 8
`define IQ_DEPTH 4
`define PTAG_COUNT 16

`endif
